//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rs_station
FLIST     ?= rs_station.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -E '\.s?v$$' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rs_checker.sv
// scoreboard for the station; a ROB index may be dispatched only once per run
`timescale 1ns/1ps

module rs_checker (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                finish,
    input  rs_pkg::way_mask_t                   dispatch_valid,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] opa,
    input  rs_pkg::way_mask_t                   opa_ready,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] opb,
    input  rs_pkg::way_mask_t                   opb_ready,
    input  rs_pkg::rob_idx_t [rs_pkg::ways-1:0] rob_idx,
    input  rs_pkg::way_mask_t                   cdb_valid,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] cdb_tag,
    input  rs_pkg::way_mask_t                   alu_occupied,
    input  rs_pkg::way_mask_t                   issue_valid,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opa,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opb,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] issue_dest_tag,
    input  rs_pkg::rob_idx_t [rs_pkg::ways-1:0] issue_rob_idx,
    input  rs_pkg::alu_op_t  [rs_pkg::ways-1:0] issue_alu_op,
    input  rs_pkg::count_t                      free_count,
    input  rs_pkg::count_t                      free_count_next,
    input  logic             [31:0]             exp_valid,
    input  rs_pkg::word_t    [31:0]             exp_opa,
    input  rs_pkg::word_t    [31:0]             exp_opb,
    input  rs_pkg::tag_t     [31:0]             exp_dest,
    input  rs_pkg::alu_op_t  [31:0]             exp_op,
    output int                                  errors,
    output logic                                reported
);

    logic         dispatched [32];
    logic         issued     [32];
    logic         wait_a     [32];
    logic         wait_b     [32];
    rs_pkg::tag_t tag_a      [32];
    rs_pkg::tag_t tag_b      [32];
    int           cyc;
    int           disp_total;
    int           iss_total;
    int           value_errors;
    int           other_errors;

    assign errors = value_errors + other_errors;

    function automatic logic on_cdb(input rs_pkg::tag_t t);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < rs_pkg::ways; w++) begin
            if (cdb_valid[w] && cdb_tag[w] == t) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        value_errors++;
    endtask

    task automatic report_violation(input string msg);
        $display("%0t: %s", $time, msg);
        other_errors++;
    endtask

    always @(posedge clock) begin
        int disp_now;
        int iss_now;
        int free_model;
        int r;
        if (reset) begin
            cyc          = 0;
            disp_total   = 0;
            iss_total    = 0;
            value_errors = 0;
            other_errors = 0;
            reported     <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                dispatched[i] = 1'b0;
                issued[i]     = 1'b0;
                wait_a[i]     = 1'b0;
                wait_b[i]     = 1'b0;
            end
        end else begin
            disp_now = 0;
            iss_now  = 0;
            for (int w = 0; w < rs_pkg::ways; w++) begin
                disp_now += int'(dispatch_valid[w]);
                iss_now  += int'(issue_valid[w]);
            end
            // count bookkeeping
            free_model = rs_pkg::rs_entries - disp_total + iss_total;
            if (int'(free_count) != free_model) begin
                report_mismatch($sformatf("free_count %0d, expected %0d", free_count,
                                          free_model));
            end
            if (int'(free_count_next) != free_model - disp_now + iss_now) begin
                report_mismatch($sformatf("free_count_next %0d, expected %0d",
                                          free_count_next,
                                          free_model - disp_now + iss_now));
            end
            for (int p = 0; p < rs_pkg::ways; p++) begin
                if (issue_valid[p]) begin
                    r = int'(issue_rob_idx[p]);
                    if (alu_occupied[p]) begin
                        report_violation($sformatf("issue on occupied port %0d", p));
                    end
                    if (!dispatched[r] || issued[r]) begin
                        report_violation($sformatf("rob %0d issued but not waiting", r));
                    end else if (wait_a[r] || wait_b[r]) begin
                        report_violation($sformatf("rob %0d issued before wakeup", r));
                    end
                    if (issue_opa[p] != exp_opa[r] || issue_opb[p] != exp_opb[r] ||
                        issue_dest_tag[p] != exp_dest[r] || issue_alu_op[p] != exp_op[r]) begin
                        report_mismatch($sformatf("rob %0d fields %h %h %h %0d", r,
                                        issue_opa[p], issue_opb[p], issue_dest_tag[p],
                                        issue_alu_op[p]));
                    end
                    issued[r] = 1'b1;
                end
            end
            // wakeup of waiting instructions
            for (int i = 0; i < 32; i++) begin
                if (wait_a[i] && on_cdb(tag_a[i])) begin
                    wait_a[i] = 1'b0;
                end
                if (wait_b[i] && on_cdb(tag_b[i])) begin
                    wait_b[i] = 1'b0;
                end
            end
            for (int w = 0; w < rs_pkg::ways; w++) begin
                if (dispatch_valid[w]) begin
                    r             = int'(rob_idx[w]);
                    dispatched[r] = 1'b1;
                    tag_a[r]      = opa[w][rs_pkg::tag_bits-1:0];
                    tag_b[r]      = opb[w][rs_pkg::tag_bits-1:0];
                    wait_a[r]     = !opa_ready[w] && !on_cdb(tag_a[r]);
                    wait_b[r]     = !opb_ready[w] && !on_cdb(tag_b[r]);
                end
            end
            disp_total += disp_now;
            iss_total  += iss_now;
            cyc++;
            if (finish && !reported) begin
                for (int i = 0; i < 32; i++) begin
                    if ((exp_valid[i] || dispatched[i]) && !issued[i]) begin
                        report_violation($sformatf("rob %0d never issued", i));
                    end
                end
                $display("checker: %0d value errors, %0d other errors over %0d cycles",
                         value_errors, other_errors, cyc);
                reported <= 1'b1;
            end
        end
    end

endmodule

//--- rs_dispatch_alloc.sv
// entry allocation and free count; upstream must never dispatch more ways than free_count allows
`timescale 1ns/1ps

module rs_dispatch_alloc (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rs_pkg::way_mask_t                         dispatch_valid,
    input  rs_pkg::entry_mask_t                       available,
    input  rs_pkg::count_t                            issue_count,
    output rs_pkg::entry_mask_t                       load,
    output rs_pkg::way_idx_t [rs_pkg::rs_entries-1:0] way_sel,
    output rs_pkg::count_t                            free_count,
    output rs_pkg::count_t                            free_count_next
);

    int             way_rank [rs_pkg::ways];
    rs_pkg::count_t load_total;

    // position of each valid way among the valid ways
    always_comb begin
        int seen;
        seen = 0;
        for (int w = 0; w < rs_pkg::ways; w++) begin
            way_rank[w] = seen;
            if (dispatch_valid[w]) begin
                seen = seen + 1;
            end
        end
    end

    // k-th valid way into k-th available entry
    always_comb begin
        int   slot;
        logic hit;
        slot    = 0;
        load    = '0;
        way_sel = '0;
        for (int e = 0; e < rs_pkg::rs_entries; e++) begin
            hit = 1'b0;
            if (available[e]) begin
                for (int w = 0; w < rs_pkg::ways; w++) begin
                    if (dispatch_valid[w] && (way_rank[w] == slot)) begin
                        hit        = 1'b1;
                        way_sel[e] = rs_pkg::way_idx_t'(w);
                    end
                end
            end
            load[e] = hit;
            if (hit) begin
                slot = slot + 1;
            end
        end
        load_total = rs_pkg::count_t'(slot);
    end

    assign free_count_next = free_count - load_total + issue_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            free_count <= rs_pkg::count_t'(rs_pkg::rs_entries);
        end else begin
            free_count <= free_count_next;
        end
    end

endmodule

//--- rs_entry.sv
// one station slot; load wins over release, so a slot can be freed and refilled at one edge
`timescale 1ns/1ps

module rs_entry (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load,
    input  logic                                release_entry,
    input  rs_pkg::way_idx_t                    way_sel,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] disp_opa,
    input  rs_pkg::way_mask_t                   disp_opa_ready,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] disp_opb,
    input  rs_pkg::way_mask_t                   disp_opb_ready,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] disp_dest_tag,
    input  rs_pkg::rob_idx_t [rs_pkg::ways-1:0] disp_rob_idx,
    input  rs_pkg::alu_op_t  [rs_pkg::ways-1:0] disp_alu_op,
    input  rs_pkg::way_mask_t                   cdb_valid,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] cdb_tag,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] cdb_data,
    output logic                                busy,
    output logic                                ready,
    output rs_pkg::word_t                       opa,
    output rs_pkg::word_t                       opb,
    output rs_pkg::tag_t                        dest_tag,
    output rs_pkg::rob_idx_t                    rob_idx,
    output rs_pkg::alu_op_t                     alu_op
);

    logic          opa_ready;
    logic          opb_ready;
    rs_pkg::word_t opa_next;
    rs_pkg::word_t opb_next;
    logic          opa_ready_next;
    logic          opb_ready_next;

    // wakeup of the stored operands
    rs_operand_capture capture_a (
        .value          (opa),
        .value_ready    (opa_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .captured       (opa_next),
        .captured_ready (opa_ready_next)
    );

    rs_operand_capture capture_b (
        .value          (opb),
        .value_ready    (opb_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .captured       (opb_next),
        .captured_ready (opb_ready_next)
    );

    assign ready = busy && opa_ready && opb_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            opa_ready <= 1'b0;
            opb_ready <= 1'b0;
        end else if (load) begin
            busy      <= 1'b1;
            opa_ready <= disp_opa_ready[way_sel];
            opb_ready <= disp_opb_ready[way_sel];
        end else if (release_entry) begin
            busy      <= 1'b0;
            opa_ready <= 1'b0;
            opb_ready <= 1'b0;
        end else if (busy) begin
            opa_ready <= opa_ready_next;
            opb_ready <= opb_ready_next;
        end
    end

    // instruction fields
    always_ff @(posedge clock) begin
        if (load) begin
            opa      <= disp_opa[way_sel];
            opb      <= disp_opb[way_sel];
            dest_tag <= disp_dest_tag[way_sel];
            rob_idx  <= disp_rob_idx[way_sel];
            alu_op   <= disp_alu_op[way_sel];
        end else if (busy) begin
            opa <= opa_next;
            opb <= opb_next;
        end
    end

endmodule

//--- rs_issue_select.sv
// issue picker; entries go out in index order, each on a free port above the last one taken
`timescale 1ns/1ps

module rs_issue_select (
    input  rs_pkg::entry_mask_t                       ready,
    input  rs_pkg::way_mask_t                         alu_occupied,
    input  rs_pkg::word_t    [rs_pkg::rs_entries-1:0] opa,
    input  rs_pkg::word_t    [rs_pkg::rs_entries-1:0] opb,
    input  rs_pkg::tag_t     [rs_pkg::rs_entries-1:0] dest_tag,
    input  rs_pkg::rob_idx_t [rs_pkg::rs_entries-1:0] rob_idx,
    input  rs_pkg::alu_op_t  [rs_pkg::rs_entries-1:0] alu_op,
    output rs_pkg::entry_mask_t                       release_entry,
    output rs_pkg::count_t                            issue_count,
    output rs_pkg::way_mask_t                         issue_valid,
    output rs_pkg::word_t    [rs_pkg::ways-1:0]       issue_opa,
    output rs_pkg::word_t    [rs_pkg::ways-1:0]       issue_opb,
    output rs_pkg::tag_t     [rs_pkg::ways-1:0]       issue_dest_tag,
    output rs_pkg::rob_idx_t [rs_pkg::ways-1:0]       issue_rob_idx,
    output rs_pkg::alu_op_t  [rs_pkg::ways-1:0]       issue_alu_op
);

    always_comb begin
        int   next_port;
        logic placed;
        next_port      = 0;
        release_entry  = '0;
        issue_count    = '0;
        issue_valid    = '0;
        issue_opa      = '0;
        issue_opb      = '0;
        issue_dest_tag = '0;
        issue_rob_idx  = '0;
        for (int p = 0; p < rs_pkg::ways; p++) begin
            issue_alu_op[p] = rs_pkg::alu_add;
        end

        for (int e = 0; e < rs_pkg::rs_entries; e++) begin
            placed = 1'b0;
            if (ready[e]) begin
                // lowest unoccupied port past the previous pick
                for (int p = 0; p < rs_pkg::ways; p++) begin
                    if (!placed && (p >= next_port) && !alu_occupied[p]) begin
                        issue_valid[p]    = 1'b1;
                        issue_opa[p]      = opa[e];
                        issue_opb[p]      = opb[e];
                        issue_dest_tag[p] = dest_tag[e];
                        issue_rob_idx[p]  = rob_idx[e];
                        issue_alu_op[p]   = alu_op[e];
                        release_entry[e]  = 1'b1;
                        next_port         = p + 1;
                        placed            = 1'b1;
                    end
                end
            end
            // unplaced entries simply wait
            if (placed) begin
                issue_count = issue_count + rs_pkg::count_t'(1);
            end
        end
    end

endmodule

//--- rs_operand_capture.sv
// operand wakeup from the CDB; a waiting operand keeps its tag in the low tag_bits of the word
`timescale 1ns/1ps

module rs_operand_capture (
    input  rs_pkg::word_t                    value,
    input  logic                             value_ready,
    input  rs_pkg::way_mask_t                cdb_valid,
    input  rs_pkg::tag_t  [rs_pkg::ways-1:0] cdb_tag,
    input  rs_pkg::word_t [rs_pkg::ways-1:0] cdb_data,
    output rs_pkg::word_t                    captured,
    output logic                             captured_ready
);

    rs_pkg::tag_t wait_tag;

    assign wait_tag = value[rs_pkg::tag_bits-1:0];

    always_comb begin
        captured       = value;
        captured_ready = value_ready;
        // only a missing operand listens to the bus
        if (!value_ready) begin
            for (int i = 0; i < rs_pkg::ways; i++) begin
                if (cdb_valid[i] && (cdb_tag[i] == wait_tag)) begin
                    captured       = cdb_data[i];
                    captured_ready = 1'b1;
                end
            end
        end
    end

endmodule

//--- rs_pkg.sv
// shared widths and types; way_idx_bits must cover ways, and operand tags sit in the low word bits
package rs_pkg;

    // machine shape
    localparam int ways         = 2;
    localparam int rs_entries   = 8;

    // field widths
    localparam int xlen         = 32;
    localparam int tag_bits     = 6;
    localparam int rob_bits     = 5;
    localparam int way_idx_bits = 1;

    typedef logic [xlen-1:0]         word_t;
    typedef logic [tag_bits-1:0]     tag_t;
    typedef logic [rob_bits-1:0]     rob_idx_t;
    typedef logic [way_idx_bits-1:0] way_idx_t;

    // free count spans 0 to rs_entries inclusive
    typedef logic [$clog2(rs_entries + 1)-1:0] count_t;

    typedef logic [ways-1:0]       way_mask_t;
    typedef logic [rs_entries-1:0] entry_mask_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_slt = 4'd7
    } alu_op_t;

endpackage

//--- rs_station.f
rs_pkg.sv
rs_operand_capture.sv
rs_entry.sv
rs_dispatch_alloc.sv
rs_issue_select.sv
rs_station.sv
rs_checker.sv
tb_rs_station.sv

//--- rs_station.sv
// reservation station top; no dispatch stall, so upstream must respect free_count
`timescale 1ns/1ps

module rs_station (
    input  logic                                clock,
    input  logic                                reset,
    input  rs_pkg::way_mask_t                   dispatch_valid,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] opa,
    input  rs_pkg::way_mask_t                   opa_ready,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] opb,
    input  rs_pkg::way_mask_t                   opb_ready,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] dest_tag,
    input  rs_pkg::rob_idx_t [rs_pkg::ways-1:0] rob_idx,
    input  rs_pkg::alu_op_t  [rs_pkg::ways-1:0] alu_op,
    input  rs_pkg::way_mask_t                   cdb_valid,
    input  rs_pkg::tag_t     [rs_pkg::ways-1:0] cdb_tag,
    input  rs_pkg::word_t    [rs_pkg::ways-1:0] cdb_data,
    input  rs_pkg::way_mask_t                   alu_occupied,
    output rs_pkg::way_mask_t                   issue_valid,
    output rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opa,
    output rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opb,
    output rs_pkg::tag_t     [rs_pkg::ways-1:0] issue_dest_tag,
    output rs_pkg::rob_idx_t [rs_pkg::ways-1:0] issue_rob_idx,
    output rs_pkg::alu_op_t  [rs_pkg::ways-1:0] issue_alu_op,
    output rs_pkg::count_t                      free_count,
    output rs_pkg::count_t                      free_count_next
);

    // dispatch operands after same-cycle CDB bypass
    rs_pkg::word_t     [rs_pkg::ways-1:0]       disp_opa;
    rs_pkg::word_t     [rs_pkg::ways-1:0]       disp_opb;
    rs_pkg::way_mask_t                          disp_opa_ready;
    rs_pkg::way_mask_t                          disp_opb_ready;

    // per entry state
    rs_pkg::entry_mask_t                        busy;
    rs_pkg::entry_mask_t                        ready;
    rs_pkg::entry_mask_t                        load;
    rs_pkg::entry_mask_t                        release_entry;
    rs_pkg::entry_mask_t                        available;
    rs_pkg::way_idx_t  [rs_pkg::rs_entries-1:0] way_sel;
    rs_pkg::word_t     [rs_pkg::rs_entries-1:0] ent_opa;
    rs_pkg::word_t     [rs_pkg::rs_entries-1:0] ent_opb;
    rs_pkg::tag_t      [rs_pkg::rs_entries-1:0] ent_dest_tag;
    rs_pkg::rob_idx_t  [rs_pkg::rs_entries-1:0] ent_rob_idx;
    rs_pkg::alu_op_t   [rs_pkg::rs_entries-1:0] ent_alu_op;
    rs_pkg::count_t                             issue_count;

    // an issuing slot can be refilled at the same edge
    assign available = ~busy | release_entry;

    for (genvar w = 0; w < rs_pkg::ways; w++) begin : g_bypass
        rs_operand_capture capture_a (
            .value          (opa[w]),
            .value_ready    (opa_ready[w]),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_data       (cdb_data),
            .captured       (disp_opa[w]),
            .captured_ready (disp_opa_ready[w])
        );

        rs_operand_capture capture_b (
            .value          (opb[w]),
            .value_ready    (opb_ready[w]),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_data       (cdb_data),
            .captured       (disp_opb[w]),
            .captured_ready (disp_opb_ready[w])
        );
    end

    for (genvar e = 0; e < rs_pkg::rs_entries; e++) begin : g_entry
        rs_entry entry (
            .clock          (clock),
            .reset          (reset),
            .load           (load[e]),
            .release_entry  (release_entry[e]),
            .way_sel        (way_sel[e]),
            .disp_opa       (disp_opa),
            .disp_opa_ready (disp_opa_ready),
            .disp_opb       (disp_opb),
            .disp_opb_ready (disp_opb_ready),
            .disp_dest_tag  (dest_tag),
            .disp_rob_idx   (rob_idx),
            .disp_alu_op    (alu_op),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_data       (cdb_data),
            .busy           (busy[e]),
            .ready          (ready[e]),
            .opa            (ent_opa[e]),
            .opb            (ent_opb[e]),
            .dest_tag       (ent_dest_tag[e]),
            .rob_idx        (ent_rob_idx[e]),
            .alu_op         (ent_alu_op[e])
        );
    end

    rs_dispatch_alloc alloc (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .available       (available),
        .issue_count     (issue_count),
        .load            (load),
        .way_sel         (way_sel),
        .free_count      (free_count),
        .free_count_next (free_count_next)
    );

    rs_issue_select select (
        .ready          (ready),
        .alu_occupied   (alu_occupied),
        .opa            (ent_opa),
        .opb            (ent_opb),
        .dest_tag       (ent_dest_tag),
        .rob_idx        (ent_rob_idx),
        .alu_op         (ent_alu_op),
        .release_entry  (release_entry),
        .issue_count    (issue_count),
        .issue_valid    (issue_valid),
        .issue_opa      (issue_opa),
        .issue_opb      (issue_opb),
        .issue_dest_tag (issue_dest_tag),
        .issue_rob_idx  (issue_rob_idx),
        .issue_alu_op   (issue_alu_op)
    );

endmodule

//--- rs_stimulus.txt
# C: way0 v opa ra opb rb dst rob op, way1 same, cdb0 v tag data, cdb1 v tag data, occ
# E: rob opa opb dst op (expected at issue), all values hex
C 1 11 1 22 1 01 00 0  1 05 0 33 1 02 01 1  0 00 0 0 00 0  0
C 1 06 0 07 0 03 02 2  0 0 0 0 0 0 0 0  1 05 aaaa 0 00 0  0
C 1 08 0 44 1 04 03 3  1 1 1 2 1 05 04 4  1 06 66 1 08 88  0
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  1 07 77 0 00 0  0
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  0
C 1 08 1 108 1 08 08 0  1 09 1 14 0 09 09 1  0 00 0 0 00 0  3
C 1 0a 1 10a 1 0a 0a 2  1 0b 1 10b 1 0b 0b 3  0 00 0 0 00 0  3
C 1 0c 1 10c 1 0c 0c 4  1 0d 1 10d 1 0d 0d 5  1 14 2020 0 00 0  3
C 1 0e 1 10e 1 0e 0e 6  1 0f 1 10f 1 0f 0f 7  0 00 0 0 00 0  3
C 1 10 1 110 1 10 10 0  1 11 1 111 1 11 11 1  0 00 0 0 00 0  0
C 1 12 1 112 1 12 12 2  1 13 1 113 1 13 13 3  0 00 0 0 00 0  0
C 1 14 1 114 1 14 14 4  1 15 1 115 1 15 15 5  0 00 0 0 00 0  0
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  1
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  0
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  0
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  2
C 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 00 0 0 00 0  0
E 00 11 22 01 0
E 01 aaaa 33 02 1
E 02 66 77 03 2
E 03 88 44 04 3
E 04 1 2 05 4
E 08 8 108 08 0
E 09 9 2020 09 1
E 0a a 10a 0a 2
E 0b b 10b 0b 3
E 0c c 10c 0c 4
E 0d d 10d 0d 5
E 0e e 10e 0e 6
E 0f f 10f 0f 7
E 10 10 110 10 0
E 11 11 111 11 1
E 12 12 112 12 2
E 13 13 113 13 3
E 14 14 114 14 4
E 15 15 115 15 5

//--- tb_rs_station.sv
// testbench top; rs_stimulus.txt is read from the working directory, at most max_cycles records
`timescale 1ns/1ps

module tb_rs_station;

    localparam int    clock_period = 20;
    localparam int    max_cycles   = 64;
    localparam int    fields       = 23;
    localparam int    drain_cycles = 6;
    localparam string stim_file    = "rs_stimulus.txt";

    logic clock;
    logic reset;
    logic finish;
    logic reported;
    logic loaded;
    logic stim_ok;
    int   errors;
    int   seed;
    int   n_cycles;
    int   cyc_fields [max_cycles][fields];

    rs_pkg::way_mask_t                   dispatch_valid;
    rs_pkg::word_t    [rs_pkg::ways-1:0] opa;
    rs_pkg::way_mask_t                   opa_ready;
    rs_pkg::word_t    [rs_pkg::ways-1:0] opb;
    rs_pkg::way_mask_t                   opb_ready;
    rs_pkg::tag_t     [rs_pkg::ways-1:0] dest_tag;
    rs_pkg::rob_idx_t [rs_pkg::ways-1:0] rob_idx;
    rs_pkg::alu_op_t  [rs_pkg::ways-1:0] alu_op;
    rs_pkg::way_mask_t                   cdb_valid;
    rs_pkg::tag_t     [rs_pkg::ways-1:0] cdb_tag;
    rs_pkg::word_t    [rs_pkg::ways-1:0] cdb_data;
    rs_pkg::way_mask_t                   alu_occupied;
    rs_pkg::way_mask_t                   issue_valid;
    rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opa;
    rs_pkg::word_t    [rs_pkg::ways-1:0] issue_opb;
    rs_pkg::tag_t     [rs_pkg::ways-1:0] issue_dest_tag;
    rs_pkg::rob_idx_t [rs_pkg::ways-1:0] issue_rob_idx;
    rs_pkg::alu_op_t  [rs_pkg::ways-1:0] issue_alu_op;
    rs_pkg::count_t                      free_count;
    rs_pkg::count_t                      free_count_next;

    // expectations indexed by ROB index
    logic             [31:0] exp_valid;
    rs_pkg::word_t    [31:0] exp_opa;
    rs_pkg::word_t    [31:0] exp_opb;
    rs_pkg::tag_t     [31:0] exp_dest;
    rs_pkg::alu_op_t  [31:0] exp_op;

    rs_station uut (
        .clock (clock), .reset (reset), .dispatch_valid (dispatch_valid),
        .opa (opa), .opa_ready (opa_ready), .opb (opb), .opb_ready (opb_ready),
        .dest_tag (dest_tag), .rob_idx (rob_idx), .alu_op (alu_op),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .cdb_data (cdb_data),
        .alu_occupied (alu_occupied), .issue_valid (issue_valid),
        .issue_opa (issue_opa), .issue_opb (issue_opb),
        .issue_dest_tag (issue_dest_tag), .issue_rob_idx (issue_rob_idx),
        .issue_alu_op (issue_alu_op), .free_count (free_count),
        .free_count_next (free_count_next)
    );

    rs_checker check (
        .clock (clock), .reset (reset), .finish (finish),
        .dispatch_valid (dispatch_valid), .opa (opa), .opa_ready (opa_ready),
        .opb (opb), .opb_ready (opb_ready), .rob_idx (rob_idx),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .alu_occupied (alu_occupied),
        .issue_valid (issue_valid), .issue_opa (issue_opa), .issue_opb (issue_opb),
        .issue_dest_tag (issue_dest_tag), .issue_rob_idx (issue_rob_idx),
        .issue_alu_op (issue_alu_op), .free_count (free_count),
        .free_count_next (free_count_next), .exp_valid (exp_valid),
        .exp_opa (exp_opa), .exp_opb (exp_opb), .exp_dest (exp_dest),
        .exp_op (exp_op), .errors (errors), .reported (reported)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // record fields: per way v opa ra opb rb dst rob op, then cdb v tag data x2, occ
    task automatic drive_cycle(input int i, input logic idle);
        int f;
        for (int w = 0; w < rs_pkg::ways; w++) begin
            f = w * 8;
            if (!idle && cyc_fields[i][f] != 0) begin
                dispatch_valid[w] <= 1'b1;
                opa[w]            <= rs_pkg::word_t'(cyc_fields[i][f+1]);
                opa_ready[w]      <= cyc_fields[i][f+2] != 0;
                opb[w]            <= rs_pkg::word_t'(cyc_fields[i][f+3]);
                opb_ready[w]      <= cyc_fields[i][f+4] != 0;
                dest_tag[w]       <= rs_pkg::tag_t'(cyc_fields[i][f+5]);
                rob_idx[w]        <= rs_pkg::rob_idx_t'(cyc_fields[i][f+6]);
                alu_op[w]         <= rs_pkg::alu_op_t'(cyc_fields[i][f+7]);
            end else begin
                // junk on an idle way
                dispatch_valid[w] <= 1'b0;
                opa[w]            <= $random(seed);
                opa_ready[w]      <= 1'($random(seed));
                opb[w]            <= $random(seed);
                opb_ready[w]      <= 1'($random(seed));
                dest_tag[w]       <= rs_pkg::tag_t'($random(seed));
                rob_idx[w]        <= rs_pkg::rob_idx_t'($random(seed));
                alu_op[w]         <= rs_pkg::alu_op_t'({1'b0, 3'($random(seed))});
            end
            f = 16 + w * 3;
            if (!idle && cyc_fields[i][f] != 0) begin
                cdb_valid[w] <= 1'b1;
                cdb_tag[w]   <= rs_pkg::tag_t'(cyc_fields[i][f+1]);
                cdb_data[w]  <= rs_pkg::word_t'(cyc_fields[i][f+2]);
            end else begin
                cdb_valid[w] <= 1'b0;
                cdb_tag[w]   <= rs_pkg::tag_t'($random(seed));
                cdb_data[w]  <= $random(seed);
            end
        end
        alu_occupied <= idle ? '0 : rs_pkg::way_mask_t'(cyc_fields[i][22]);
    endtask

    task automatic load_stimulus(output logic ok);
        int                fd;
        int                code;
        int                r;
        int                v [5];
        logic [8*8-1:0]    tok;
        logic [8*256-1:0]  line;
        ok = 1'b1;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stim_file);
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) break;
                if (tok == "#") begin
                    code = $fgets(line, fd);
                end else if (tok == "C" && n_cycles < max_cycles) begin
                    for (int k = 0; k < fields; k++) begin
                        code = $fscanf(fd, "%h", cyc_fields[n_cycles][k]);
                    end
                    n_cycles++;
                end else if (tok == "E") begin
                    for (int k = 0; k < 5; k++) begin
                        code = $fscanf(fd, "%h", v[k]);
                    end
                    r            = v[0] & 31;
                    exp_valid[r] = 1'b1;
                    exp_opa[r]   = rs_pkg::word_t'(v[1]);
                    exp_opb[r]   = rs_pkg::word_t'(v[2]);
                    exp_dest[r]  = rs_pkg::tag_t'(v[3]);
                    exp_op[r]    = rs_pkg::alu_op_t'(v[4]);
                end else begin
                    $display("unknown record in the stimulus file");
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    // watchdog sized from the stimulus length
    initial begin
        wait (loaded);
        #((n_cycles + 50) * clock_period);
        $display("timeout: the run did not reach its end in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed      = 32'hab6b_3424;
        loaded    = 1'b0;
        n_cycles  = 0;
        reset     = 1'b1;
        finish    = 1'b0;
        exp_valid = '0;
        exp_opa   = '0;
        exp_opb   = '0;
        exp_dest  = '0;
        for (int r = 0; r < 32; r++) begin
            exp_op[r] = rs_pkg::alu_add;
        end
        dispatch_valid = '0;
        opa            = '0;
        opa_ready      = '0;
        opb            = '0;
        opb_ready      = '0;
        dest_tag       = '0;
        rob_idx        = '0;
        for (int w = 0; w < rs_pkg::ways; w++) begin
            alu_op[w] = rs_pkg::alu_add;
        end
        cdb_valid      = '0;
        cdb_tag        = '0;
        cdb_data       = '0;
        alu_occupied   = '0;
        load_stimulus(stim_ok);
        loaded = 1'b1;

        if (!stim_ok) begin
            $display("FAIL: see errors above");
            $finish;
        end else begin
            repeat (3) @(posedge clock);
            reset <= 1'b0;
            for (int i = 0; i < n_cycles; i++) begin
                drive_cycle(i, 1'b0);
                @(posedge clock);
            end
            drive_cycle(0, 1'b1);
            repeat (drain_cycles) @(posedge clock);
            finish <= 1'b1;
            wait (reported === 1'b1);
            if (errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule
